//--- Makefile
VERILATOR ?= verilator
TOP ?= mem_subsys_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- mem_subsys_stimulus.txt
# kind funct3 addr wdata expect, init puts wdata low and expect high in one beat
# store expect is the wstrb, both has the fetch pc in the wdata column
init 0 00001000 80f17e02 c3a45b96
init 0 00002000 33221100 77665544
fetch 0 00001000 00000000 80f17e02
fetch 0 00001004 00000000 c3a45b96
load 0 00001000 00000000 00000002
load 4 00001001 00000000 0000007e
load 0 00001002 00000000 fffffff1
load 4 00001003 00000000 00000080
load 0 00001004 00000000 ffffff96
load 4 00001005 00000000 0000005b
load 0 00001006 00000000 ffffffa4
load 0 00001007 00000000 ffffffc3
load 1 00001000 00000000 00007e02
load 5 00001002 00000000 000080f1
load 1 00001004 00000000 00005b96
load 1 00001006 00000000 ffffc3a4
load 2 00001000 00000000 80f17e02
load 2 00001004 00000000 c3a45b96
store 2 00002000 deadbeef 0000000f
store 0 00002001 123456a5 00000002
store 1 00002006 9abc5a11 000000c0
load 2 00002000 00000000 deada5ef
load 2 00002004 00000000 5a115544
both 2 00001004 00001000 c3a45b96
mtime 2 0200bff8 00000000 00000000
store 2 0200bff8 00000001 00000000
fetch 0 0000f000 00000000 00000000
load 2 0000f008 00000000 00000000
store 2 0000f010 11111111 0000000f

//--- rtl/bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
	input  logic             clock,
	input  logic             arst_n,
	input  mem_pkg::bus_ar_t ifu_ar,
	input  logic             ifu_ar_valid,
	output logic             ifu_ar_ready,
	output mem_pkg::bus_r_t  ifu_r,
	output logic             ifu_r_valid,
	input  mem_pkg::bus_ar_t lsu_ar,
	input  logic             lsu_ar_valid,
	output logic             lsu_ar_ready,
	output mem_pkg::bus_r_t  lsu_r,
	output logic             lsu_r_valid,
	input  mem_pkg::bus_aw_t lsu_aw,
	input  logic             lsu_aw_valid,
	output logic             lsu_aw_ready,
	input  mem_pkg::bus_w_t  lsu_w,
	input  logic             lsu_w_valid,
	output logic             lsu_w_ready,
	output mem_pkg::resp_t   lsu_b,
	output logic             lsu_b_valid,
	output mem_pkg::bus_ar_t clint_ar,
	output logic             clint_ar_valid,
	input  mem_pkg::bus_r_t  clint_r,
	input  logic             clint_r_valid,
	output mem_pkg::bus_ar_t m_ar,
	output logic             m_ar_valid,
	input  logic             m_ar_ready,
	input  mem_pkg::bus_r_t  m_r,
	input  logic             m_r_valid,
	output logic             m_r_ready,
	output mem_pkg::bus_aw_t m_aw,
	output logic             m_aw_valid,
	input  logic             m_aw_ready,
	output mem_pkg::bus_w_t  m_w,
	output logic             m_w_valid,
	input  logic             m_w_ready,
	input  mem_pkg::resp_t   m_b,
	input  logic             m_b_valid,
	output logic             m_b_ready
);
	import mem_pkg::*;

	typedef enum logic [1:0] {g_idle, g_ifu, g_lsu} grant_t;

	grant_t  state;
	logic    to_clint_q;
	logic    wr_q;
	logic    sel_lsu, sel_ifu;
	addr_t   req_addr;
	logic    tgt_clint;
	bus_ar_t ar_src;
	logic    ar_src_valid;
	logic    ar_rdy;
	logic    addr_hs;
	bus_r_t  r_src;
	logic    r_src_valid;
	logic    resp_hs;

	assign sel_lsu = (state == g_lsu) || (state == g_idle && (lsu_ar_valid || lsu_aw_valid));
	assign sel_ifu = (state == g_ifu) || (state == g_idle && !sel_lsu && ifu_ar_valid);
	assign req_addr = sel_lsu ? (lsu_aw_valid ? lsu_aw.addr : lsu_ar.addr) : ifu_ar.addr;
	assign tgt_clint = (state == g_idle) ? ((req_addr & clint_mask) == clint_base) : to_clint_q;

	assign ar_src = sel_lsu ? lsu_ar : ifu_ar;
	assign ar_src_valid = sel_lsu ? lsu_ar_valid : (sel_ifu && ifu_ar_valid);
	assign ar_rdy = tgt_clint | m_ar_ready; // clint never stalls ar
	assign m_ar = ar_src;
	assign m_ar_valid = ar_src_valid && !tgt_clint;
	assign clint_ar = ar_src;
	assign clint_ar_valid = ar_src_valid && tgt_clint;
	assign ifu_ar_ready = sel_ifu && ar_rdy;
	assign lsu_ar_ready = sel_lsu && ar_rdy;

	assign m_aw = lsu_aw;
	assign m_aw_valid = sel_lsu && lsu_aw_valid && !tgt_clint;
	assign lsu_aw_ready = sel_lsu && (tgt_clint || m_aw_ready);
	assign m_w = lsu_w;
	assign m_w_valid = sel_lsu && lsu_w_valid && !tgt_clint;
	assign lsu_w_ready = sel_lsu && (tgt_clint || m_w_ready); // clint writes are dropped

	assign r_src = to_clint_q ? clint_r : m_r;
	assign r_src_valid = to_clint_q ? clint_r_valid : m_r_valid;
	assign ifu_r = r_src;
	assign ifu_r_valid = (state == g_ifu) && r_src_valid;
	assign lsu_r = r_src;
	assign lsu_r_valid = (state == g_lsu) && !wr_q && r_src_valid;
	assign lsu_b = to_clint_q ? resp_slverr : m_b;
	assign lsu_b_valid = (state == g_lsu) && wr_q && (to_clint_q ? !lsu_w_valid : m_b_valid);
	assign m_r_ready = 1'b1;
	assign m_b_ready = 1'b1;

	assign addr_hs = (sel_lsu && ((lsu_ar_valid && lsu_ar_ready) || (lsu_aw_valid && lsu_aw_ready)))
		|| (sel_ifu && ifu_ar_valid && ifu_ar_ready);
	assign resp_hs = ifu_r_valid || lsu_r_valid || lsu_b_valid;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= g_idle;
			to_clint_q <= 1'b0;
			wr_q <= 1'b0;
		end else if (state == g_idle) begin
			if (addr_hs) begin // grant latches here
				state <= sel_lsu ? g_lsu : g_ifu;
				to_clint_q <= tgt_clint;
				wr_q <= sel_lsu && lsu_aw_valid;
			end
		end else if (resp_hs) begin
			state <= g_idle;
		end
	end

endmodule

`default_nettype wire

//--- rtl/clint_timer.sv
`timescale 1ns/10ps
`default_nettype none

module clint_timer (
	input  logic             clock,
	input  logic             arst_n,
	input  mem_pkg::bus_ar_t ar,
	input  logic             ar_valid,
	output mem_pkg::bus_r_t  r,
	output logic             r_valid
);
	import mem_pkg::*;

	beat_t mtime;
	beat_t rdata_q;

	assign r = '{data: rdata_q, resp: resp_okay};

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			mtime <= '0;
			r_valid <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1; // free running
			r_valid <= ar_valid; // arready is always high
		end
	end

	always_ff @(posedge clock) begin
		if (ar_valid) rdata_q <= (ar.addr[15:3] == clint_mtime[15:3]) ? mtime : '0;
	end

endmodule

`default_nettype wire

//--- rtl/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
	input  logic             clock,
	input  logic             arst_n,
	input  logic             fetch_req,
	input  mem_pkg::addr_t   fetch_pc,
	output mem_pkg::bus_ar_t ar,
	output logic             ar_valid,
	input  logic             ar_ready,
	input  mem_pkg::bus_r_t  r,
	input  logic             r_valid,
	output mem_pkg::word_t   fetch_inst,
	output logic             fetch_done,
	output logic             fetch_err
);
	import mem_pkg::*;

	typedef enum logic {s_idle, s_wait} state_t;

	state_t state;
	addr_t  pc_q;

	assign ar = '{addr: pc_q, size: 3'd2}; // always a 4 byte read

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= s_idle;
			ar_valid <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			case (state)
				s_idle: if (fetch_req) begin
					state <= s_wait;
					ar_valid <= 1'b1;
				end
				s_wait: begin
					if (ar_ready) ar_valid <= 1'b0;
					if (r_valid) begin // rready tied high
						state <= s_idle;
						fetch_done <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == s_idle && fetch_req) pc_q <= fetch_pc;
		if (state == s_wait && r_valid) begin
			fetch_inst <= pc_q[2] ? r.data[63:32] : r.data[31:0]; // lane by pc[2]
			fetch_err <= |r.resp;
		end
	end

endmodule

`default_nettype wire

//--- rtl/load_store_unit.sv
`timescale 1ns/10ps
`default_nettype none

module load_store_unit (
	input  logic              clock,
	input  logic              arst_n,
	input  logic              req_valid,
	input  mem_pkg::lsu_req_t req,
	output logic              req_ready,
	output mem_pkg::bus_ar_t  ar,
	output logic              ar_valid,
	input  logic              ar_ready,
	input  mem_pkg::bus_r_t   r,
	input  logic              r_valid,
	output mem_pkg::bus_aw_t  aw,
	output logic              aw_valid,
	input  logic              aw_ready,
	output mem_pkg::bus_w_t   w,
	output logic              w_valid,
	input  logic              w_ready,
	input  mem_pkg::resp_t    b_resp,
	input  logic              b_valid,
	output mem_pkg::word_t    lsu_rdata,
	output logic              lsu_done,
	output logic              lsu_err
);
	import mem_pkg::*;

	typedef enum logic [1:0] {s_idle, s_read, s_write, s_resp} state_t;

	state_t   state;
	lsu_req_t req_q;
	logic     [2:0] off;
	strb_t    mask;
	beat_t    rshift;
	word_t    load_val;
	logic     resp_hs;

	assign req_ready = (state == s_idle);
	assign off = req_q.addr[2:0];
	assign ar = '{addr: req_q.addr, size: {1'b0, req_q.funct3[1:0]}};
	assign aw = '{addr: req_q.addr, size: {1'b0, req_q.funct3[1:0]}};
	assign w.data = beat_t'(req_q.wdata) << {off, 3'b000}; // byte lane placement
	assign w.strb = mask << off;
	assign rshift = r.data >> {off, 3'b000};
	assign resp_hs = (state == s_resp) && (req_q.store ? b_valid : r_valid);

	always_comb begin
		case (req_q.funct3[1:0])
			2'b00: mask = 8'h01;
			2'b01: mask = 8'h03;
			default: mask = 8'h0f;
		endcase
	end

	always_comb begin
		case (req_q.funct3)
			f3_b: load_val = {{24{rshift[7]}}, rshift[7:0]};
			f3_h: load_val = {{16{rshift[15]}}, rshift[15:0]};
			f3_bu: load_val = {24'b0, rshift[7:0]};
			f3_hu: load_val = {16'b0, rshift[15:0]};
			default: load_val = rshift[31:0]; // lw
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= s_idle;
			ar_valid <= 1'b0;
			aw_valid <= 1'b0;
			w_valid <= 1'b0;
			lsu_done <= 1'b0;
		end else begin
			lsu_done <= 1'b0;
			case (state)
				s_idle: if (req_valid) begin
					state <= req.store ? s_write : s_read;
					ar_valid <= !req.store;
					aw_valid <= req.store;
					w_valid <= req.store;
				end
				s_read: if (ar_ready) begin
					ar_valid <= 1'b0;
					state <= s_resp;
				end
				s_write: begin
					if (aw_ready) aw_valid <= 1'b0; // aw and w drop on their own
					if (w_ready) w_valid <= 1'b0;
					if ((!aw_valid || aw_ready) && (!w_valid || w_ready)) state <= s_resp;
				end
				s_resp: if (resp_hs) begin
					state <= s_idle;
					lsu_done <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (req_ready && req_valid) req_q <= req;
		if (resp_hs) begin
			lsu_rdata <= req_q.store ? '0 : load_val;
			lsu_err <= req_q.store ? |b_resp : |r.resp;
		end
	end

endmodule

`default_nettype wire

//--- rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [63:0] beat_t;
	typedef logic [7:0]  strb_t;
	typedef logic [1:0]  resp_t;
	typedef logic [2:0]  funct3_t;

	typedef struct packed {
		addr_t      addr;
		logic [2:0] size; // log2 of bytes
	} bus_ar_t;

	typedef bus_ar_t bus_aw_t; // same payload as ar

	typedef struct packed {
		beat_t data;
		resp_t resp;
	} bus_r_t;

	typedef struct packed {
		beat_t data;
		strb_t strb;
	} bus_w_t;

	typedef struct packed {
		logic    store;
		funct3_t funct3;
		addr_t   addr;
		word_t   wdata;
	} lsu_req_t;

	localparam funct3_t f3_b  = 3'b000;
	localparam funct3_t f3_h  = 3'b001;
	localparam funct3_t f3_w  = 3'b010;
	localparam funct3_t f3_bu = 3'b100;
	localparam funct3_t f3_hu = 3'b101;

	localparam resp_t resp_okay   = 2'b00;
	localparam resp_t resp_slverr = 2'b10;

	localparam addr_t clint_base  = 32'h0200_0000;
	localparam addr_t clint_mask  = 32'hffff_0000; // 64 KiB window
	localparam addr_t clint_mtime = 32'h0000_bff8; // offset inside window

endpackage

`default_nettype wire

//--- rtl/mem_subsys_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top (
	input  logic              clock,
	input  logic              arst_n,
	input  logic              fetch_req,
	input  mem_pkg::addr_t    fetch_pc,
	output mem_pkg::word_t    fetch_inst,
	output logic              fetch_done,
	output logic              fetch_err,
	input  logic              lsu_req_valid,
	input  mem_pkg::lsu_req_t lsu_req,
	output logic              lsu_req_ready,
	output mem_pkg::word_t    lsu_rdata,
	output logic              lsu_done,
	output logic              lsu_err,
	output mem_pkg::bus_ar_t  m_ar,
	output logic              m_ar_valid,
	input  logic              m_ar_ready,
	input  mem_pkg::bus_r_t   m_r,
	input  logic              m_r_valid,
	output logic              m_r_ready,
	output mem_pkg::bus_aw_t  m_aw,
	output logic              m_aw_valid,
	input  logic              m_aw_ready,
	output mem_pkg::bus_w_t   m_w,
	output logic              m_w_valid,
	input  logic              m_w_ready,
	input  mem_pkg::resp_t    m_b,
	input  logic              m_b_valid,
	output logic              m_b_ready
);
	import mem_pkg::*;

	bus_ar_t ifu_ar, lsu_ar, clint_ar;
	logic    ifu_ar_valid, ifu_ar_ready, lsu_ar_valid, lsu_ar_ready, clint_ar_valid;
	bus_r_t  ifu_r, lsu_r, clint_r;
	logic    ifu_r_valid, lsu_r_valid, clint_r_valid;
	bus_aw_t lsu_aw;
	logic    lsu_aw_valid, lsu_aw_ready;
	bus_w_t  lsu_w;
	logic    lsu_w_valid, lsu_w_ready;
	resp_t   lsu_b;
	logic    lsu_b_valid;

	fetch_unit ifu0 (
		.clock(clock), .arst_n(arst_n),
		.fetch_req(fetch_req), .fetch_pc(fetch_pc),
		.ar(ifu_ar), .ar_valid(ifu_ar_valid), .ar_ready(ifu_ar_ready),
		.r(ifu_r), .r_valid(ifu_r_valid),
		.fetch_inst(fetch_inst), .fetch_done(fetch_done), .fetch_err(fetch_err)
	);

	load_store_unit lsu0 (
		.clock(clock), .arst_n(arst_n),
		.req_valid(lsu_req_valid), .req(lsu_req), .req_ready(lsu_req_ready),
		.ar(lsu_ar), .ar_valid(lsu_ar_valid), .ar_ready(lsu_ar_ready),
		.r(lsu_r), .r_valid(lsu_r_valid),
		.aw(lsu_aw), .aw_valid(lsu_aw_valid), .aw_ready(lsu_aw_ready),
		.w(lsu_w), .w_valid(lsu_w_valid), .w_ready(lsu_w_ready),
		.b_resp(lsu_b), .b_valid(lsu_b_valid),
		.lsu_rdata(lsu_rdata), .lsu_done(lsu_done), .lsu_err(lsu_err)
	);

	bus_arbiter arb0 (
		.clock(clock), .arst_n(arst_n),
		.ifu_ar(ifu_ar), .ifu_ar_valid(ifu_ar_valid), .ifu_ar_ready(ifu_ar_ready),
		.ifu_r(ifu_r), .ifu_r_valid(ifu_r_valid),
		.lsu_ar(lsu_ar), .lsu_ar_valid(lsu_ar_valid), .lsu_ar_ready(lsu_ar_ready),
		.lsu_r(lsu_r), .lsu_r_valid(lsu_r_valid),
		.lsu_aw(lsu_aw), .lsu_aw_valid(lsu_aw_valid), .lsu_aw_ready(lsu_aw_ready),
		.lsu_w(lsu_w), .lsu_w_valid(lsu_w_valid), .lsu_w_ready(lsu_w_ready),
		.lsu_b(lsu_b), .lsu_b_valid(lsu_b_valid),
		.clint_ar(clint_ar), .clint_ar_valid(clint_ar_valid),
		.clint_r(clint_r), .clint_r_valid(clint_r_valid),
		.m_ar(m_ar), .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready),
		.m_r(m_r), .m_r_valid(m_r_valid), .m_r_ready(m_r_ready),
		.m_aw(m_aw), .m_aw_valid(m_aw_valid), .m_aw_ready(m_aw_ready),
		.m_w(m_w), .m_w_valid(m_w_valid), .m_w_ready(m_w_ready),
		.m_b(m_b), .m_b_valid(m_b_valid), .m_b_ready(m_b_ready)
	);

	clint_timer clint0 (
		.clock(clock), .arst_n(arst_n),
		.ar(clint_ar), .ar_valid(clint_ar_valid),
		.r(clint_r), .r_valid(clint_r_valid)
	);

endmodule

`default_nettype wire

//--- verif/mem_subsys_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_tb;
	import mem_pkg::*;

	localparam addr_t fault_lo = 32'h0000_f000;
	localparam addr_t fault_hi = 32'h0000_f0ff;
	localparam int timeout_cycles = 1000;

	logic     clock;
	logic     arst_n;
	logic     fetch_req;
	addr_t    fetch_pc;
	word_t    fetch_inst;
	logic     fetch_done;
	logic     fetch_err;
	logic     lsu_req_valid;
	lsu_req_t lsu_req;
	logic     lsu_req_ready;
	word_t    lsu_rdata;
	logic     lsu_done;
	logic     lsu_err;
	bus_ar_t  m_ar;
	logic     m_ar_valid;
	logic     m_ar_ready = 1'b0;
	bus_r_t   m_r = '0;
	logic     m_r_valid = 1'b0;
	logic     m_r_ready;
	bus_aw_t  m_aw;
	logic     m_aw_valid;
	logic     m_aw_ready = 1'b0;
	bus_w_t   m_w;
	logic     m_w_valid;
	logic     m_w_ready = 1'b0;
	resp_t    m_b = resp_okay;
	logic     m_b_valid = 1'b0;
	logic     m_b_ready;

	// external memory model state, keyed by beat index
	beat_t       mem [addr_t];
	beat_t       init_mem [addr_t];
	logic [31:0] rng = 32'h1791a8a3;
	logic        busy = 1'b0;
	logic        rd_pend = 1'b0;
	logic        wr_pend = 1'b0;
	logic        got_aw = 1'b0;
	logic        got_w = 1'b0;
	logic [1:0]  delay = 2'd0;
	addr_t       rd_addr = '0;
	addr_t       wr_addr = '0;
	bus_w_t      wr_beat = '0;
	strb_t       last_strb = '0;
	int          ext_writes = 0;

	// stimulus and results
	int             fd;
	int             n;
	int             op;
	int             writes;
	logic [63:0]    kind;
	logic [1023:0]  rest;
	funct3_t        f3;
	addr_t          addr;
	word_t          wdata;
	word_t          expv;
	word_t          first;
	string          name;
	lsu_req_t       req;
	word_t          got_inst;
	logic           got_ferr;
	word_t          got_rdata;
	logic           got_lerr;
	word_t          fetch_exp [addr_t]; // expected words of earlier fetch lines

	tb_clock_gen clk0 (.clock(clock), .arst_n(arst_n));

	mem_subsys_top dut0 (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic in_fault(input addr_t a);
		return (a >= fault_lo) && (a <= fault_hi);
	endfunction

	function automatic logic in_clint(input addr_t a);
		return (a & clint_mask) == clint_base;
	endfunction

	function automatic beat_t read_beat(input addr_t a);
		addr_t idx;
		idx = a >> 3;
		if (mem.exists(idx)) return mem[idx];
		if (init_mem.exists(idx)) return init_mem[idx];
		return {~idx, idx ^ 32'h5a5a_c3c3}; // fill follows the beat address
	endfunction

	task automatic fail_test(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string tname, input word_t exp, input word_t act);
		if (act !== exp)
			fail_test($sformatf("mismatch %s: expected %h, actual %h", tname, exp, act));
	endtask

	task automatic check_resp(input string tname, input logic exp, input logic act);
		if (act !== exp)
			fail_test($sformatf("mismatch %s: expected err %b, actual err %b", tname, exp, act));
	endtask

	task automatic check_strb(input string tname, input strb_t exp, input strb_t act);
		if (act !== exp)
			fail_test($sformatf("mismatch %s: expected wstrb %h, actual wstrb %h", tname, exp, act));
	endtask

	task automatic apply_write(input addr_t a, input bus_w_t wb);
		beat_t beat;
		beat = read_beat(a);
		for (int i = 0; i < 8; i++) begin
			if (wb.strb[i]) beat[i*8 +: 8] = wb.data[i*8 +: 8];
		end
		if (!in_fault(a)) mem[a >> 3] = beat;
		last_strb = wb.strb;
		ext_writes++;
	endtask

	// external bus slave with random ready and response delays
	always @(negedge clock) begin
		if (arst_n) begin
			if (m_r_valid && m_r_ready !== 1'b1)
				fail_test("read response was not accepted by the DUT");
			if (m_b_valid && m_b_ready !== 1'b1)
				fail_test("write response was not accepted by the DUT");
			if (m_r_valid || m_b_valid) begin // rready and bready are high
				m_r_valid = 1'b0;
				m_b_valid = 1'b0;
				busy = 1'b0;
			end
			if (rd_pend || wr_pend) begin
				if (delay != 2'd0) begin
					delay = delay - 2'd1;
				end else if (rd_pend) begin
					m_r = '{data: read_beat(rd_addr), resp: in_fault(rd_addr) ? resp_slverr : resp_okay};
					m_r_valid = 1'b1;
					rd_pend = 1'b0;
				end else begin
					m_b = in_fault(wr_addr) ? resp_slverr : resp_okay;
					m_b_valid = 1'b1;
					wr_pend = 1'b0;
				end
			end
			rng = xorshift32(rng);
			m_ar_ready = |rng[1:0];
			m_aw_ready = |rng[3:2];
			m_w_ready = |rng[5:4];
			if ((m_ar_valid && m_ar_ready) || (m_aw_valid && m_aw_ready)) begin
				if (busy)
					fail_test("external bus took a second address before the first response");
				busy = 1'b1;
			end
			if (m_ar_valid && m_ar_ready) begin
				rd_pend = 1'b1;
				rd_addr = m_ar.addr;
				delay = rng[9:8];
			end
			if (m_aw_valid && m_aw_ready) begin
				got_aw = 1'b1;
				wr_addr = m_aw.addr;
			end
			if (m_w_valid && m_w_ready) begin
				got_w = 1'b1;
				wr_beat = m_w;
			end
			if (got_aw && got_w) begin
				apply_write(wr_addr, wr_beat);
				got_aw = 1'b0;
				got_w = 1'b0;
				wr_pend = 1'b1;
				delay = rng[11:10];
			end
		end
	end

	// starts a fetch, a load/store request or both, then waits for their done pulses
	task automatic run_ops(input logic do_f, input addr_t pc, input logic do_l, input lsu_req_t r);
		int   cnt;
		logic f_wait;
		logic l_wait;
		cnt = 0;
		while (do_l && !lsu_req_ready) begin
			if (cnt == timeout_cycles) fail_test("load/store unit never became idle");
			@(negedge clock);
			cnt++;
		end
		fetch_pc = pc;
		fetch_req = do_f;
		lsu_req = r;
		lsu_req_valid = do_l;
		@(negedge clock);
		fetch_req = 1'b0;
		lsu_req_valid = 1'b0;
		if (do_l && lsu_req_ready)
			fail_test("load/store unit still idle after taking a request");
		f_wait = do_f;
		l_wait = do_l;
		cnt = 0;
		while (f_wait || l_wait) begin
			if (cnt == timeout_cycles) fail_test("no done pulse within 1000 cycles");
			@(negedge clock);
			cnt++;
			if (fetch_done) begin
				f_wait = 1'b0;
				got_inst = fetch_inst;
				got_ferr = fetch_err;
			end
			if (lsu_done) begin
				l_wait = 1'b0;
				got_rdata = lsu_rdata;
				got_lerr = lsu_err;
			end
		end
	endtask

	initial begin
		fetch_req = 1'b0;
		fetch_pc = '0;
		lsu_req_valid = 1'b0;
		lsu_req = '0;
		fd = $fopen("mem_subsys_stimulus.txt", "r");
		if (fd == 0) fail_test("cannot open mem_subsys_stimulus.txt");
		n = 0;
		while (arst_n !== 1'b1) begin
			if (n == 100) fail_test("reset was never released");
			@(negedge clock);
			n++;
		end
		@(negedge clock);
		op = 0;
		while ($fscanf(fd, "%s", kind) == 1) begin
			if (kind == 64'("#")) begin
				void'($fgets(rest, fd));
			end else begin
				if ($fscanf(fd, "%h %h %h %h", f3, addr, wdata, expv) != 4)
					fail_test($sformatf("malformed stimulus line after op %0d", op));
				op++;
				name = $sformatf("op %0d at %h", op, addr);
				req = '{store: 1'b0, funct3: f3, addr: addr, wdata: wdata};
				if (kind == 64'("init")) begin
					init_mem[addr >> 3] = {expv, wdata}; // high word in expect column
				end else if (kind == 64'("fetch")) begin
					run_ops(1'b1, addr, 1'b0, req);
					check_resp(name, in_fault(addr), got_ferr);
					if (!in_fault(addr)) begin
						check_word(name, expv, got_inst);
						fetch_exp[addr] = expv;
					end
				end else if (kind == 64'("load")) begin
					run_ops(1'b0, '0, 1'b1, req);
					check_resp(name, in_fault(addr), got_lerr);
					if (!in_fault(addr)) check_word(name, expv, got_rdata);
				end else if (kind == 64'("store")) begin
					req.store = 1'b1;
					writes = ext_writes;
					run_ops(1'b0, '0, 1'b1, req);
					check_resp(name, in_fault(addr) || in_clint(addr), got_lerr);
					if (!in_clint(addr)) begin
						check_strb(name, expv[7:0], last_strb);
					end else if (ext_writes != writes) begin
						fail_test($sformatf("%s: CLINT store reached the external bus", name));
					end
				end else if (kind == 64'("both")) begin
					if (!fetch_exp.exists(wdata))
						fail_test($sformatf("%s: no earlier fetch line gives the word at %h",
							name, wdata));
					run_ops(1'b1, wdata, 1'b1, req);
					check_word({name, " fetch"}, fetch_exp[wdata], got_inst);
					check_word({name, " load"}, expv, got_rdata);
				end else if (kind == 64'("mtime")) begin
					run_ops(1'b0, '0, 1'b1, req);
					check_resp(name, 1'b0, got_lerr);
					first = got_rdata;
					run_ops(1'b0, '0, 1'b1, req);
					check_resp(name, 1'b0, got_lerr);
					if (got_rdata <= first)
						fail_test($sformatf("%s: mtime went from %h to %h", name, first, got_rdata));
				end else begin
					fail_test($sformatf("unknown operation in stimulus file at op %0d", op));
				end
			end
		end
		$fclose(fd);
		if (op == 0) begin
			fail_test("stimulus file held no operations");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic arst_n
);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock; // 100 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (10) @(posedge clock);
		#25 arst_n = 1'b1; // released between edges
	end

endmodule

`default_nettype wire

//--- vlog.f
rtl/mem_pkg.sv
rtl/fetch_unit.sv
rtl/load_store_unit.sv
rtl/bus_arbiter.sv
rtl/clint_timer.sv
rtl/mem_subsys_top.sv
verif/tb_clock_gen.sv
verif/mem_subsys_tb.sv
